//--- design/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;

    typedef enum logic [1:0] {
        MODE_U = 2'b00,
        MODE_S = 2'b01,
        MODE_M = 2'b11
    } priv_mode_t;

    // kept mstatus fields, msb first
    typedef struct packed {
        logic [18:0] rsv_31_13;
        logic [1:0]  mpp;
        logic [1:0]  rsv_10_9;
        logic        spp;
        logic        mpie;
        logic        rsv_6;
        logic        spie;
        logic        rsv_4;
        logic        mie;
        logic        rsv_2;
        logic        sie;
        logic        rsv_0;
    } mstatus_t;

    typedef union packed {
        word_t    raw; // reads, masked writes, sstatus
        mstatus_t f;   // trap and return
    } status_u;

    typedef struct packed {
        logic breakpoint;
        logic illegal_inst;
        logic fetch_misalign;
        logic ecall;
        logic store_misalign;
        logic load_misalign;
        logic mret;
        logic sret;
    } except_t;

    // highest priority first
    typedef struct packed {
        logic mei, msi, mti;
        logic sei, ssi, sti;
    } irq_t;

    typedef struct packed {
        status_u mstatus;
        word_t   misa;
        word_t   mhartid;
        word_t   medeleg;
        word_t   mideleg;
        word_t   mie;
        word_t   mip;
        word_t   mtvec;
        word_t   stvec;
        word_t   mscratch;
        word_t   sscratch;
        word_t   mepc;
        word_t   sepc;
        word_t   mcause;
        word_t   scause;
        word_t   mtval;
        word_t   stval;
    } csr_file_t;

    typedef struct packed {
        csr_addr_t raddr;
        csr_addr_t waddr;
        logic      we;
        word_t     wdata;
    } csr_req_t;

    typedef struct packed {
        logic  take_trap;
        logic  is_irq;
        logic  to_smode;
        word_t cause;
        word_t tval;
        word_t vector;
    } trap_info_t;

    localparam csr_addr_t CSR_SSTATUS  = 12'h100;
    localparam csr_addr_t CSR_SIE      = 12'h104;
    localparam csr_addr_t CSR_STVEC    = 12'h105;
    localparam csr_addr_t CSR_SSCRATCH = 12'h140;
    localparam csr_addr_t CSR_SEPC     = 12'h141;
    localparam csr_addr_t CSR_SCAUSE   = 12'h142;
    localparam csr_addr_t CSR_STVAL    = 12'h143;
    localparam csr_addr_t CSR_SIP      = 12'h144;
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MISA     = 12'h301;
    localparam csr_addr_t CSR_MEDELEG  = 12'h302;
    localparam csr_addr_t CSR_MIDELEG  = 12'h303;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MHARTID  = 12'hf14;

    localparam word_t MSTATUS_WMASK = 32'h0000_19aa;
    localparam word_t SSTATUS_MASK  = 32'h0000_0122; // sie, spie, spp
    localparam word_t MIE_WMASK     = 32'h0000_0aaa;
    localparam word_t SIE_MASK      = 32'h0000_0222;
    localparam word_t MIP_WMASK     = 32'h0000_0222; // machine bits come from the lines
    localparam word_t SIP_MASK      = 32'h0000_0222;
    localparam word_t MEDELEG_WMASK = 32'h0000_035d;
    localparam word_t MIDELEG_WMASK = 32'h0000_0222;
    localparam word_t MEPC_WMASK    = 32'hffff_fffc;

    localparam word_t CAUSE_FETCH_MISALIGN = 32'd0;
    localparam word_t CAUSE_ILLEGAL_INST   = 32'd2;
    localparam word_t CAUSE_BREAKPOINT     = 32'd3;
    localparam word_t CAUSE_LOAD_MISALIGN  = 32'd4;
    localparam word_t CAUSE_STORE_MISALIGN = 32'd6;
    localparam word_t CAUSE_ECALL_U        = 32'd8;
    localparam word_t CAUSE_ECALL_S        = 32'd9;
    localparam word_t CAUSE_ECALL_M        = 32'd11;

    // interrupt codes double as mip/mie bit positions
    localparam word_t CAUSE_SSI = 32'd1;
    localparam word_t CAUSE_MSI = 32'd3;
    localparam word_t CAUSE_STI = 32'd5;
    localparam word_t CAUSE_MTI = 32'd7;
    localparam word_t CAUSE_SEI = 32'd9;
    localparam word_t CAUSE_MEI = 32'd11;
    localparam int    IRQ_BIT   = 31;

    localparam word_t MISA_INIT    = 32'h4014_1101; // rv32imasu
    localparam word_t MSTATUS_INIT = 32'h0000_0000;
    localparam word_t MHARTID_INIT = 32'h0000_0000;

endpackage

//--- design/csr_access_decode.sv
`timescale 1ns/1ps

module csr_access_decode import csr_pkg::*; (
    input  csr_req_t   req,
    input  except_t    exc,
    input  csr_file_t  state,
    input  priv_mode_t mode,
    input  word_t      pend_mip,
    output word_t      rdata,
    output logic       illegal
);

    logic write_ro;
    logic low_priv;
    logic sret_bad;

    // top two address bits 11 mark a read-only csr
    assign write_ro = req.we && (req.waddr[11:10] == 2'b11);

    // bits 9:8 hold the lowest mode allowed to touch the csr
    assign low_priv = (2'(mode) < req.raddr[9:8])
                    || (req.we && (2'(mode) < req.waddr[9:8]));

    assign sret_bad = exc.sret && (mode == MODE_U);

    assign illegal = write_ro | low_priv | sret_bad | exc.illegal_inst;

    always_comb begin
        case (req.raddr)
            // s-mode views of the m-mode registers
            CSR_SSTATUS:  rdata = state.mstatus.raw & SSTATUS_MASK;
            CSR_SIE:      rdata = state.mie & SIE_MASK & state.mideleg;
            CSR_SIP:      rdata = pend_mip & SIP_MASK & state.mideleg;
            CSR_STVEC:    rdata = state.stvec;
            CSR_SSCRATCH: rdata = state.sscratch;
            CSR_SEPC:     rdata = state.sepc;
            CSR_SCAUSE:   rdata = state.scause;
            CSR_STVAL:    rdata = state.stval;
            CSR_MSTATUS:  rdata = state.mstatus.raw;
            CSR_MISA:     rdata = state.misa;
            CSR_MEDELEG:  rdata = state.medeleg;
            CSR_MIDELEG:  rdata = state.mideleg;
            CSR_MIE:      rdata = state.mie;
            CSR_MIP:      rdata = pend_mip; // includes the live lines
            CSR_MTVEC:    rdata = state.mtvec;
            CSR_MSCRATCH: rdata = state.mscratch;
            CSR_MEPC:     rdata = state.mepc;
            CSR_MCAUSE:   rdata = state.mcause;
            CSR_MTVAL:    rdata = state.mtval;
            CSR_MHARTID:  rdata = state.mhartid;
            default:      rdata = '0;
        endcase
    end

endmodule

//--- design/trap_select.sv
`timescale 1ns/1ps

module trap_select import csr_pkg::*; (
    input  except_t    exc,
    input  logic       illegal,
    input  csr_file_t  state,
    input  priv_mode_t mode,
    input  word_t      inst,
    input  word_t      pc,
    input  word_t      mem_addr,
    input  logic       timer_irq,
    input  logic       ext_irq,
    output word_t      pend_mip,
    output trap_info_t trap
);

    logic  m_glob, s_glob;
    irq_t  irq_pend, irq_en, irq_take;
    logic  irq_any, exc_any;
    word_t irq_cause, exc_cause, exc_val;
    word_t cause, tvec, tvec_base;
    logic  to_smode;

    always_comb begin
        pend_mip = state.mip;
        pend_mip[CAUSE_MTI] = state.mip[CAUSE_MTI] | timer_irq;
        pend_mip[CAUSE_MEI] = state.mip[CAUSE_MEI] | ext_irq;
    end

    // global enables: lower modes are always interruptible
    assign m_glob = (mode != MODE_M) || state.mstatus.f.mie;
    assign s_glob = (mode == MODE_U) || ((mode == MODE_S) && state.mstatus.f.sie);

    assign irq_pend = '{mei: pend_mip[CAUSE_MEI], msi: pend_mip[CAUSE_MSI],
                        mti: pend_mip[CAUSE_MTI], sei: pend_mip[CAUSE_SEI],
                        ssi: pend_mip[CAUSE_SSI], sti: pend_mip[CAUSE_STI]};

    always_comb begin
        irq_en.mei = m_glob & state.mie[CAUSE_MEI];
        irq_en.msi = m_glob & state.mie[CAUSE_MSI];
        irq_en.mti = m_glob & state.mie[CAUSE_MTI];
        // s-level lines follow s enables only when delegated
        irq_en.sei = (state.mideleg[CAUSE_SEI] ? s_glob : m_glob) & state.mie[CAUSE_SEI];
        irq_en.ssi = (state.mideleg[CAUSE_SSI] ? s_glob : m_glob) & state.mie[CAUSE_SSI];
        irq_en.sti = (state.mideleg[CAUSE_STI] ? s_glob : m_glob) & state.mie[CAUSE_STI];
    end

    assign irq_take = irq_pend & irq_en;
    assign irq_any  = |irq_take;

    always_comb begin
        if (irq_take.mei)      irq_cause = CAUSE_MEI;
        else if (irq_take.msi) irq_cause = CAUSE_MSI;
        else if (irq_take.mti) irq_cause = CAUSE_MTI;
        else if (irq_take.sei) irq_cause = CAUSE_SEI;
        else if (irq_take.ssi) irq_cause = CAUSE_SSI;
        else                   irq_cause = CAUSE_STI;
        irq_cause[IRQ_BIT] = 1'b1;
    end

    assign exc_any = exc.breakpoint | illegal | exc.fetch_misalign | exc.ecall
                   | exc.store_misalign | exc.load_misalign;

    always_comb begin
        exc_cause = CAUSE_LOAD_MISALIGN;
        exc_val   = mem_addr;
        if (exc.breakpoint) begin
            exc_cause = CAUSE_BREAKPOINT;
            exc_val   = pc;
        end else if (illegal) begin
            exc_cause = CAUSE_ILLEGAL_INST;
            exc_val   = inst;
        end else if (exc.fetch_misalign) begin
            exc_cause = CAUSE_FETCH_MISALIGN;
            exc_val   = pc;
        end else if (exc.ecall) begin
            case (mode)
                MODE_U:  exc_cause = CAUSE_ECALL_U;
                MODE_S:  exc_cause = CAUSE_ECALL_S;
                default: exc_cause = CAUSE_ECALL_M;
            endcase
            exc_val = '0;
        end else if (exc.store_misalign) begin
            exc_cause = CAUSE_STORE_MISALIGN;
        end
    end

    assign cause    = irq_any ? irq_cause : exc_cause;
    assign to_smode = (mode != MODE_M)
                    && (irq_any ? state.mideleg[cause[4:0]] : state.medeleg[cause[4:0]]);

    assign tvec      = to_smode ? state.stvec : state.mtvec;
    assign tvec_base = {tvec[31:2], 2'b00};

    assign trap.take_trap = irq_any | exc_any;
    assign trap.is_irq    = irq_any;
    assign trap.to_smode  = to_smode;
    assign trap.cause     = cause;
    assign trap.tval      = exc_val;
    // vectored mode only offsets interrupts, shift drops the irq flag
    assign trap.vector    = (irq_any && tvec[1:0] == 2'b01) ? tvec_base + (cause << 2)
                                                            : tvec_base;

endmodule

//--- design/csr_state_update.sv
`timescale 1ns/1ps

module csr_state_update import csr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  csr_req_t   req,
    input  except_t    exc,
    input  trap_info_t trap,
    input  word_t      pc,
    output csr_file_t  state,
    output priv_mode_t mode,
    output logic       flush,
    output word_t      redirect_pc
);

    csr_file_t  state_nxt;
    priv_mode_t mode_nxt;
    word_t      trap_val;
    word_t      sie_wmask;

    assign flush     = trap.take_trap | exc.mret | exc.sret | req.we;
    assign trap_val  = trap.is_irq ? '0 : trap.tval;
    assign sie_wmask = SIE_MASK & state.mideleg;

    always_comb begin
        state_nxt   = state;
        mode_nxt    = mode;
        redirect_pc = {pc[31:2] + 30'd1, 2'b00}; // next inst after a csr write
        if (trap.take_trap) begin
            redirect_pc = trap.vector;
            if (trap.to_smode) begin
                state_nxt.scause         = trap.cause;
                state_nxt.sepc           = pc;
                state_nxt.stval          = trap_val;
                state_nxt.mstatus.f.spie = state.mstatus.f.sie;
                state_nxt.mstatus.f.sie  = 1'b0;
                state_nxt.mstatus.f.spp  = mode[0];
                mode_nxt                 = MODE_S;
            end else begin
                state_nxt.mcause         = trap.cause;
                state_nxt.mepc           = pc;
                state_nxt.mtval          = trap_val;
                state_nxt.mstatus.f.mpie = state.mstatus.f.mie;
                state_nxt.mstatus.f.mie  = 1'b0;
                state_nxt.mstatus.f.mpp  = mode;
                mode_nxt                 = MODE_M;
            end
        end else if (exc.mret) begin
            state_nxt.mstatus.f.mie  = state.mstatus.f.mpie;
            state_nxt.mstatus.f.mpie = 1'b1;
            state_nxt.mstatus.f.mpp  = MODE_U;
            mode_nxt                 = priv_mode_t'(state.mstatus.f.mpp);
            redirect_pc              = state.mepc;
        end else if (exc.sret) begin
            state_nxt.mstatus.f.sie  = state.mstatus.f.spie;
            state_nxt.mstatus.f.spie = 1'b1;
            state_nxt.mstatus.f.spp  = 1'b0;
            mode_nxt                 = state.mstatus.f.spp ? MODE_S : MODE_U;
            redirect_pc              = state.sepc;
        end else if (req.we) begin
            case (req.waddr)
                CSR_SSTATUS: state_nxt.mstatus.raw = (state.mstatus.raw & ~SSTATUS_MASK)
                                                   | (req.wdata & SSTATUS_MASK);
                CSR_SIE:      state_nxt.mie = (state.mie & ~sie_wmask) | (req.wdata & sie_wmask);
                CSR_SIP:      state_nxt.mip = (state.mip & ~(SIP_MASK & state.mideleg))
                                            | (req.wdata & SIP_MASK & state.mideleg);
                CSR_STVEC:    state_nxt.stvec    = req.wdata;
                CSR_SSCRATCH: state_nxt.sscratch = req.wdata;
                CSR_SEPC:     state_nxt.sepc     = req.wdata & MEPC_WMASK;
                CSR_SCAUSE:   state_nxt.scause   = req.wdata;
                CSR_STVAL:    state_nxt.stval    = req.wdata;
                CSR_MSTATUS: begin
                    state_nxt.mstatus.raw = req.wdata & MSTATUS_WMASK;
                    // mpp 2'b10 is reserved
                    if (state_nxt.mstatus.f.mpp == 2'b10) begin
                        state_nxt.mstatus.f.mpp = MODE_U;
                    end
                end
                CSR_MEDELEG:  state_nxt.medeleg  = req.wdata & MEDELEG_WMASK;
                CSR_MIDELEG:  state_nxt.mideleg  = req.wdata & MIDELEG_WMASK;
                CSR_MIE:      state_nxt.mie      = req.wdata & MIE_WMASK;
                CSR_MIP:      state_nxt.mip      = req.wdata & MIP_WMASK;
                CSR_MTVEC:    state_nxt.mtvec    = req.wdata;
                CSR_MSCRATCH: state_nxt.mscratch = req.wdata;
                CSR_MEPC:     state_nxt.mepc     = req.wdata & MEPC_WMASK;
                CSR_MCAUSE:   state_nxt.mcause   = req.wdata;
                CSR_MTVAL:    state_nxt.mtval    = req.wdata;
                default:      state_nxt          = state; // misa is warl, fixed here
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state             <= '0;
            state.mstatus.raw <= MSTATUS_INIT;
            state.misa        <= MISA_INIT;
            state.mhartid     <= MHARTID_INIT;
            mode              <= MODE_M;
        end else begin
            state <= state_nxt;
            mode  <= mode_nxt;
        end
    end

endmodule

//--- design/csr_unit.sv
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  csr_req_t   req,
    input  except_t    exc,
    input  word_t      inst,
    input  word_t      pc,
    input  word_t      mem_addr,
    input  logic       timer_irq,
    input  logic       ext_irq,
    output word_t      rdata,
    output priv_mode_t mode,
    output logic       flush,
    output word_t      redirect_pc
);

    csr_file_t  state;
    logic       illegal;
    word_t      pend_mip;
    trap_info_t trap;

    csr_access_decode decode_i (
        .req      (req),
        .exc      (exc),
        .state    (state),
        .mode     (mode),
        .pend_mip (pend_mip),
        .rdata    (rdata),
        .illegal  (illegal)
    );

    trap_select select_i (
        .exc       (exc),
        .illegal   (illegal),
        .state     (state),
        .mode      (mode),
        .inst      (inst),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .timer_irq (timer_irq),
        .ext_irq   (ext_irq),
        .pend_mip  (pend_mip),
        .trap      (trap)
    );

    csr_state_update update_i (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .exc         (exc),
        .trap        (trap),
        .pc          (pc),
        .state       (state),
        .mode        (mode),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

//--- bench/csr_tb_checks.svh
`ifndef CSR_TB_CHECKS_SVH
`define CSR_TB_CHECKS_SVH

int test_errs;    // mismatches in the running test
int tests_run;
int tests_failed;

task automatic check_word(input string test, input string what,
                          input word_t expected, input word_t actual);
    if (actual !== expected) begin
        $display("[FAIL] %s %s: expected %h, actual %h", test, what, expected, actual);
        test_errs++;
    end
endtask

task automatic check_mode(input string test, input string what,
                          input priv_mode_t expected, input priv_mode_t actual);
    if (actual !== expected) begin
        $display("[FAIL] %s %s: expected %s (%b), actual %b",
                 test, what, expected.name(), expected, actual);
        test_errs++;
    end
endtask

task automatic check_flag(input string test, input string what,
                          input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("[FAIL] %s %s: expected %b, actual %b", test, what, expected, actual);
        test_errs++;
    end
endtask

`endif

//--- bench/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

    logic       clk;
    logic       rst;
    csr_req_t   req;
    except_t    exc;
    word_t      inst;
    word_t      pc;
    word_t      mem_addr;
    logic       timer_irq;
    logic       ext_irq;
    word_t      rdata;
    priv_mode_t mode;
    logic       flush;
    word_t      redirect_pc;

    string lines[$];
    int    fd;
    int    cycle_count = 0;
    int    cycle_limit = 20;

    `include "csr_tb_checks.svh"

    csr_unit dut_i (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .exc         (exc),
        .inst        (inst),
        .pc          (pc),
        .mem_addr    (mem_addr),
        .timer_irq   (timer_irq),
        .ext_irq     (ext_irq),
        .rdata       (rdata),
        .mode        (mode),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: no finish after %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    function automatic priv_mode_t mode_from_letter(input string s);
        if (s == "U") return MODE_U;
        if (s == "S") return MODE_S;
        return MODE_M;
    endfunction

    task automatic read_lines(input int f);
        string line;
        int    r;
        while (!$feof(f)) begin
            r = $fgets(line, f);
            // skip comments and blank lines
            if (r > 0 && line.len() > 1 && line[0] != "#") lines.push_back(line);
        end
    endtask

    task automatic run_line(input string line);
        string      name;
        string      e_rdata, e_flush, e_redir, e_mode;
        csr_addr_t  rd_addr, wr_addr;
        logic       wr_en, t_line, e_line;
        word_t      wr_data, v_inst, v_pc, v_mem, exp_word;
        logic [7:0] exc_bits;
        logic       exp_flag;
        int         n;
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %s %s %s %s",
                    name, rd_addr, wr_addr, wr_en, wr_data, exc_bits, v_inst, v_pc,
                    v_mem, t_line, e_line, e_rdata, e_flush, e_redir, e_mode);
        tests_run++;
        test_errs = 0;
        if (n != 15) begin
            $display("stimulus line %0d has %0d fields instead of 15", tests_run, n);
            tests_failed++;
        end else begin
            @(negedge clk);
            req.raddr = rd_addr;
            req.waddr = wr_addr;
            req.we    = wr_en;
            req.wdata = wr_data;
            exc       = except_t'(exc_bits);
            inst      = v_inst;
            pc        = v_pc;
            mem_addr  = v_mem;
            timer_irq = t_line;
            ext_irq   = e_line;
            #1; // settled, ahead of the rising edge
            if (e_rdata != "-") begin
                n = $sscanf(e_rdata, "%h", exp_word);
                check_word(name, "rdata", exp_word, rdata);
            end
            if (e_flush != "-") begin
                n = $sscanf(e_flush, "%b", exp_flag);
                check_flag(name, "flush", exp_flag, flush);
            end
            if (e_redir != "-") begin
                n = $sscanf(e_redir, "%h", exp_word);
                check_word(name, "redirect_pc", exp_word, redirect_pc);
            end
            @(posedge clk);
            #1;
            if (e_mode != "-") check_mode(name, "mode", mode_from_letter(e_mode), mode);
            if (test_errs == 0) begin
                $display("test %s: ok", name);
            end else begin
                $display("test %s: %0d mismatches", name, test_errs);
                tests_failed++;
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        exc       = '0;
        inst      = '0;
        pc        = '0;
        mem_addr  = '0;
        timer_irq = 1'b0;
        ext_irq   = 1'b0;
        fd = $fopen("bench/csr_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/csr_stim.txt for reading");
            $display("Something failed");
            $finish;
        end else begin
            read_lines(fd);
            $fclose(fd);
            cycle_limit = lines.size() * 2 + 20;
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            foreach (lines[i]) begin
                run_line(lines[i]);
            end
            $display("tests: %0d run, %0d passed, %0d failed",
                     tests_run, tests_run - tests_failed, tests_failed);
            if (tests_failed == 0 && tests_run > 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+bench
design/csr_pkg.sv
design/csr_access_decode.sv
design/trap_select.sv
design/csr_state_update.sv
design/csr_unit.sv
bench/csr_unit_tb.sv

//--- bench/csr_stim.txt
# name raddr waddr we wdata exc inst pc mem_addr timer ext | rdata flush redirect_pc next_mode
# exc bits msb first: brk ill fmis ecall smis lmis mret sret; a '-' skips that check
rst_misa      301 000 0 00000000 00 00000013 00001000 00000000 0 0 40141101 0 -        M
rst_mhartid   f14 000 0 00000000 00 00000013 00001000 00000000 0 0 00000000 0 -        M
rst_mstatus   300 000 0 00000000 00 00000013 00001000 00000000 0 0 00000000 0 -        M
wr_mscratch   340 340 1 deadbeef 00 00000013 00001000 00000000 0 0 00000000 1 00001004 M
rd_mscratch   340 000 0 00000000 00 00000013 00001004 00000000 0 0 deadbeef 0 -        M
wr_mstatus    300 300 1 ffffffff 00 00000013 0000100a 00000000 0 0 00000000 1 0000100c M
rd_mstatus    300 000 0 00000000 00 00000013 0000100c 00000000 0 0 000019aa 0 -        M
rd_sstatus    100 000 0 00000000 00 00000013 0000100c 00000000 0 0 00000122 0 -        M
wr_mtvec      305 305 1 00008000 00 00000013 00001010 00000000 0 0 00000000 1 00001014 M
wr_mhartid    f14 f14 1 00000005 00 12345673 00001020 00000000 0 0 00000000 1 00008000 M
rd_mcause_ro  342 000 0 00000000 00 00000013 00008000 00000000 0 0 00000002 0 -        M
rd_mtval_ro   343 000 0 00000000 00 00000013 00008000 00000000 0 0 12345673 0 -        M
rd_mepc_ro    341 000 0 00000000 00 00000013 00008000 00000000 0 0 00001020 0 -        M
ecall_m       300 000 0 00000000 10 00000073 00002000 00000000 0 0 000019a2 1 00008000 M
rd_mcause_ec  342 000 0 00000000 00 00000013 00008000 00000000 0 0 0000000b 0 -        M
rd_mepc_ec    341 000 0 00000000 00 00000013 00008000 00000000 0 0 00002000 0 -        M
wr_mpp_s      300 300 1 00000800 00 00000013 00002100 00000000 0 0 00001922 1 00002104 M
mret_to_s     300 000 0 00000000 02 30200073 00003000 00000000 0 0 00000800 1 00002000 S
rd_sstatus_s  100 000 0 00000000 00 00000013 00002000 00000000 0 0 00000000 0 -        S
rd_m_from_s   340 000 0 00000000 00 abcd0073 00004000 00000000 0 0 -        1 00008000 M
rd_mcause_s   342 000 0 00000000 00 00000013 00008000 00000000 0 0 00000002 0 -        M
rd_mtval_s    343 000 0 00000000 00 00000013 00008000 00000000 0 0 abcd0073 0 -        M
wr_medeleg    302 302 1 00000200 00 00000013 00004100 00000000 0 0 00000000 1 00004104 M
wr_stvec      105 105 1 0000a000 00 00000013 00004104 00000000 0 0 00000000 1 00004108 M
mret_to_s2    300 000 0 00000000 02 30200073 00004108 00000000 0 0 00000800 1 00004000 S
ecall_s       100 000 0 00000000 10 00000073 00005000 00000000 0 0 00000000 1 0000a000 S
rd_scause     142 000 0 00000000 00 00000013 0000a000 00000000 0 0 00000009 0 -        S
rd_sepc       141 000 0 00000000 00 00000013 0000a000 00000000 0 0 00005000 0 -        S
rd_sstatus_t  100 000 0 00000000 00 00000013 0000a000 00000000 0 0 00000100 0 -        S
sret          100 000 0 00000000 01 10200073 00006000 00000000 0 0 00000100 1 00005000 S
brk_to_m      100 000 0 00000000 80 00100073 00007000 00000000 0 0 00000020 1 00008000 M
rd_mtval_brk  343 000 0 00000000 00 00000013 00008000 00000000 0 0 00007000 0 -        M
wr_mtvec_vec  305 305 1 00009001 00 00000013 00007100 00000000 0 0 00008000 1 00007104 M
wr_mie_mtie   304 304 1 00000080 00 00000013 00007104 00000000 0 0 00000000 1 00007108 M
wr_mstat_mie  300 300 1 00000008 00 00000013 00007108 00000000 0 0 00000820 1 0000710c M
timer_ecall   304 000 0 00000000 10 00000073 0000b000 00000000 1 0 00000080 1 0000901c M
rd_mcause_irq 342 000 0 00000000 00 00000013 0000901c 00000000 0 0 80000007 0 -        M
rd_mepc_irq   341 000 0 00000000 00 00000013 0000901c 00000000 0 0 0000b000 0 -        M
rd_mip_line   344 000 0 00000000 00 00000013 0000901c 00000000 1 0 00000080 0 -        M
